// ==== include/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// 8N1 character size
`define UART_DATA_BITS 8

// one bit time is baud_div clk cycles
`define UART_DIV_BITS 16

`define UART_FIFO_DEPTH 16 // default for both byte queues

`endif

// ==== logic/uart_pkg.sv ====
`default_nettype none

`include "uart_params.svh"

package uart_pkg;

    // one serial character
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // receive FIFO entry, byte plus its stop-bit check
    typedef struct packed {
        uart_byte_t data;
        logic       frame_err; // stop bit was sampled low
    } uart_rx_word_t;

    typedef struct packed {
        logic tx_full;
        logic tx_empty;
        logic rx_ready;  // registered copy of rx count != 0
    } uart_status_t;

endpackage

`default_nettype wire

// ==== logic/uart_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_fifo #(
    parameter type payload_t = logic [`UART_DATA_BITS-1:0],
    parameter int  DEPTH     = `UART_FIFO_DEPTH
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       push,
    input  wire payload_t                   wr_data,
    input  wire logic                       pop,
    output payload_t                        rd_data,
    output logic [$clog2(DEPTH+1)-1:0]      count,
    output logic                            full,
    output logic                            empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              do_push;
    logic              do_pop;

    // wraps correctly for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count == DEPTH);
    assign empty   = (count == '0);
    assign do_push = push && !full;   // push on a full queue is lost
    assign do_pop  = pop && !empty;
    assign rd_data = mem[rd_ptr];     // head is visible without a read cycle

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leaves occupancy alone
            endcase
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= DEPTH);

    // pointers only meet when the queue is empty or full
    a_ptr_count: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_ptr == rd_ptr) == (empty || full));

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_tx (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [`UART_DIV_BITS-1:0]  baud_div,
    input  wire logic                       start,
    input  wire uart_pkg::uart_byte_t       data,
    output logic                            tx_pin,
    output logic                            idle
);
    localparam int FRAME_BITS = `UART_DATA_BITS + 2;   // start + data + stop
    localparam int IDX_W      = $clog2(FRAME_BITS);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(FRAME_BITS - 1);

    logic [`UART_DIV_BITS-1:0] baud_cnt;
    logic [IDX_W-1:0]          bit_idx;
    logic [FRAME_BITS-1:0]     shift_q;
    logic                      bit_end;

    assign bit_end = (baud_cnt == baud_div - 1'b1);

    // line is the low end of the shifter, ones are shifted in behind the frame
    assign tx_pin = shift_q[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            shift_q  <= '1;     // idle line high
            idle     <= 1'b1;
        end else if (idle) begin
            if (start) begin
                shift_q  <= {1'b1, data, 1'b0};
                baud_cnt <= '0;
                bit_idx  <= '0;
                idle     <= 1'b0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            shift_q  <= {1'b1, shift_q[FRAME_BITS-1:1]};
            if (bit_idx == LAST_BIT) begin
                idle <= 1'b1;   // stop bit has run its full time
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // the top level must hold off while a frame is on the line
    a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> idle);

    a_pin_high_idle: assert property (@(posedge clk) disable iff (!rst_n)
        idle |-> tx_pin);

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_rx (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [`UART_DIV_BITS-1:0]  baud_div,
    input  wire logic                       rx_pin,
    output logic                            done,
    output uart_pkg::uart_rx_word_t         word
);
    import uart_pkg::*;

    localparam int IDX_W = $clog2(`UART_DATA_BITS);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(`UART_DATA_BITS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t                    state;
    logic [1:0]                sync_q;
    logic                      rx_s;
    logic                      rx_prev;
    logic [`UART_DIV_BITS-1:0] baud_cnt;
    logic [`UART_DIV_BITS-1:0] half_div;
    logic [IDX_W-1:0]          bit_idx;
    logic                      bit_end;
    logic                      half_end;
    logic                      sample_data;
    logic                      sample_stop;
    uart_byte_t                data_q;

    assign rx_s        = sync_q[1];
    assign half_div    = baud_div >> 1;
    assign half_end    = (baud_cnt == half_div - 1'b1);  // middle of start bit
    assign bit_end     = (baud_cnt == baud_div - 1'b1);
    assign sample_data = (state == ST_DATA) && bit_end;
    assign sample_stop = (state == ST_STOP) && bit_end;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            sync_q   <= 2'b11;
            rx_prev  <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
            done     <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], rx_pin};
            rx_prev <= rx_s;
            done    <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (rx_prev && !rx_s) begin  // falling edge arms the receiver
                        state    <= ST_START;
                        baud_cnt <= '0;
                    end
                end
                ST_START: begin
                    if (half_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        // a high line here was a glitch, not a start bit
                        state    <= rx_s ? ST_IDLE : ST_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (bit_idx == LAST_BIT) state <= ST_STOP;
                        else bit_idx <= bit_idx + 1'b1;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        done     <= 1'b1;
                        state    <= ST_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload path, lsb arrives first
    always_ff @(posedge clk) begin
        if (sample_data) begin
            data_q <= {rx_s, data_q[`UART_DATA_BITS-1:1]};
        end
        if (sample_stop) begin
            word.data      <= data_q;
            word.frame_err <= !rx_s;   // stop bit must be high
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

endmodule

`default_nettype wire

// ==== logic/uart.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [`UART_DIV_BITS-1:0]  baud_div,
    input  wire logic                       tx_start,
    input  wire uart_pkg::uart_byte_t       tx_data,
    output logic                            tx_pin,
    input  wire logic                       rx_pin,
    input  wire logic                       rx_read,
    output uart_pkg::uart_rx_word_t         rx_word,
    output uart_pkg::uart_status_t          status
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(`UART_FIFO_DEPTH + 1);

    // transmit side
    logic          tx_start_q;      // toggle detector
    logic          tx_push;
    logic          tx_pop;
    logic          tx_full;
    logic          tx_empty;
    logic          tx_go;           // start pulse to the serializer
    logic          tx_idle;
    uart_byte_t    tx_head;
    uart_byte_t    tx_byte;

    // receive side
    logic          rx_read_q;
    logic          rx_pop_q;
    logic          rx_done;
    logic          rx_push;
    logic          rx_pop;
    logic          rx_full;
    logic          rx_empty;
    logic          rx_ready_q;
    uart_rx_word_t rx_new;
    uart_rx_word_t rx_head;
    logic [CNT_W-1:0] rx_count;

    assign tx_push = tx_start ^ tx_start_q;  // either edge enqueues
    // skip a cycle after each start so idle has time to drop
    assign tx_pop  = !tx_empty && tx_idle && !tx_go;
    assign rx_push = rx_done && !rx_full;    // overflow words are dropped
    assign rx_pop  = rx_pop_q && !rx_empty;

    assign status = '{tx_full: tx_full, tx_empty: tx_empty, rx_ready: rx_ready_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_start_q <= 1'b0;
            rx_read_q  <= 1'b0;
            rx_pop_q   <= 1'b0;
            tx_go      <= 1'b0;
            rx_ready_q <= 1'b0;
            rx_word    <= '0;
        end else begin
            tx_start_q <= tx_start;
            rx_read_q  <= rx_read;
            rx_pop_q   <= rx_read ^ rx_read_q;  // registered pop strobe
            tx_go      <= tx_pop;
            rx_ready_q <= (rx_count != '0);
            if (rx_pop) rx_word <= rx_head;     // held until the next pop
        end
    end

    always_ff @(posedge clk) begin
        if (tx_pop) tx_byte <= tx_head;
    end

    uart_fifo #(
        .payload_t (uart_byte_t)
    ) i_tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (tx_push),
        .wr_data (tx_data),
        .pop     (tx_pop),
        .rd_data (tx_head),
        .count   (),
        .full    (tx_full),
        .empty   (tx_empty)
    );

    uart_fifo #(
        .payload_t (uart_rx_word_t)
    ) i_rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (rx_push),
        .wr_data (rx_new),
        .pop     (rx_pop),
        .rd_data (rx_head),
        .count   (rx_count),
        .full    (rx_full),
        .empty   (rx_empty)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .baud_div (baud_div),
        .start    (tx_go),
        .data     (tx_byte),
        .tx_pin   (tx_pin),
        .idle     (tx_idle)
    );

    uart_rx i_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .baud_div (baud_div),
        .rx_pin   (rx_pin),
        .done     (rx_done),
        .word     (rx_new)
    );

endmodule

`default_nettype wire

// ==== tests/uart_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD = 4;   // 8 ns clock

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset spans 10 rising edges and lifts on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/uart_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_checker (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    tx_pin,
    input  wire logic                    rx_read,
    input  wire uart_pkg::uart_rx_word_t rx_word,
    input  wire uart_pkg::uart_status_t  status,
    input  wire logic                    exp_push,
    input  wire uart_pkg::uart_rx_word_t exp_word,
    input  wire logic                    stat_req,
    input  wire logic                    pin_chk,
    input  wire uart_pkg::uart_status_t  stat_exp,
    input  wire logic                    test_end,
    input  wire logic                    final_req,
    input  wire logic [7:0]              test_num,
    output int                           error_count
);
    import uart_pkg::*;

    uart_rx_word_t exp_q[$];   // words the DUT still owes us, oldest first
    uart_status_t  stat_exp_q;
    logic          rd_prev;
    logic [1:0]    pop_d;
    logic          stat_q;
    logic          pin_q;
    logic          end_q;
    logic          fin_q;
    logic [7:0]    num_q;
    int            row_errs = 0;
    int            row_checks = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            word_checks = 0;

    initial error_count = 0;

    task automatic note_error();
        error_count++;
        row_errs++;
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED test %0d: %s got 0x%0h expected 0x%0h", num_q, name, got, exp);
            note_error();
        end
    endtask

    task automatic check_word();
        uart_rx_word_t exp;
        word_checks++;
        row_checks++;
        if (exp_q.size() == 0) begin
            $display("test %0d: a word was popped although none was expected", num_q);
            note_error();
        end else begin
            exp = exp_q.pop_front();
            if (rx_word.data !== exp.data) begin
                $display("FAILED test %0d: rx_word.data got 0x%02h expected 0x%02h",
                         num_q, rx_word.data, exp.data);
                note_error();
            end
            compare_flag("rx_word.frame_err", rx_word.frame_err, exp.frame_err);
        end
    endtask

    task automatic check_status();
        compare_flag("status.tx_full", status.tx_full, stat_exp_q.tx_full);
        compare_flag("status.tx_empty", status.tx_empty, stat_exp_q.tx_empty);
        compare_flag("status.rx_ready", status.rx_ready, stat_exp_q.rx_ready);
        if (pin_q) compare_flag("tx_pin", tx_pin, 1'b1);   // line idles high
    endtask

    task automatic report_test();
        if (exp_q.size() != 0) begin
            $display("test %0d: %0d expected words were never popped", num_q, exp_q.size());
            note_error();
            exp_q.delete();
        end
        tests_run++;
        if (row_errs == 0) begin
            $display("test %0d passed, %0d words compared", num_q, row_checks);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", num_q, row_errs);
        end
        row_errs   = 0;
        row_checks = 0;
    endtask

    // requests from the testbench are taken on the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_prev <= 1'b0;
            pop_d   <= 2'b00;
        end else begin
            rd_prev <= rx_read;
            pop_d   <= {pop_d[0], rx_read ^ rd_prev};  // rx_word settles two edges on
        end
        stat_q     <= stat_req;
        pin_q      <= pin_chk;
        stat_exp_q <= stat_exp;
        end_q      <= test_end;
        fin_q      <= final_req;
        num_q      <= test_num;
        if (exp_push) exp_q.push_back(exp_word);
    end

    // DUT outputs are compared half a cycle after they change
    always @(negedge clk) begin
        if (pop_d[1]) check_word();
        if (stat_q) check_status();
        if (end_q) report_test();
        if (fin_q) begin
            $display("%0d tests, %0d passed, %0d failed, %0d words compared, %0d errors",
                     tests_run, tests_run - tests_failed, tests_failed, word_checks,
                     error_count);
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_uart.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module tb_uart;
    import uart_pkg::*;

    localparam int DEPTH  = `UART_FIFO_DEPTH;
    localparam int MAXB   = DEPTH + 3;
    localparam int NROWS  = 6;
    localparam int MARGIN = 5000;   // reset plus slack, in cycles

    // row kinds
    localparam int K_RESET    = 0;
    localparam int K_LOOP     = 1;
    localparam int K_TXFULL   = 2;
    localparam int K_FRAME    = 3;
    localparam int K_OVERFLOW = 4;

    logic                      clk;
    logic                      rst_n;
    logic [`UART_DIV_BITS-1:0] baud_div;
    logic                      tx_start;
    uart_byte_t                tx_data;
    logic                      tx_pin;
    logic                      rx_pin;
    logic                      rx_read;
    uart_rx_word_t             rx_word;
    uart_status_t              status;
    logic                      loopback;
    logic                      drv_pin;   // bit-banged serial source
    logic                      exp_push;
    uart_rx_word_t             exp_word;
    logic                      stat_req;
    logic                      pin_chk;
    uart_status_t              stat_exp;
    logic                      test_end;
    logic                      final_req;
    logic [7:0]                test_num;
    int                        error_count;

    // stimulus table, one entry per test
    int                        row_kind[NROWS];
    int                        row_len[NROWS];
    int                        row_exp[NROWS];   // words that must come back
    int                        row_baud[NROWS];
    logic [MAXB-1:0]           row_bad_stop[NROWS];
    uart_byte_t                row_data[NROWS][MAXB];

    int unsigned               seed = 32'h1d12_c1db;
    int unsigned               rnd;
    int                        cycles = 0;
    int                        cycle_limit = 1000000;

    assign rx_pin = loopback ? tx_pin : drv_pin;

    uart_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    uart i_uart (
        .clk      (clk),
        .rst_n    (rst_n),
        .baud_div (baud_div),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_pin   (tx_pin),
        .rx_pin   (rx_pin),
        .rx_read  (rx_read),
        .rx_word  (rx_word),
        .status   (status)
    );

    uart_checker i_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_pin      (tx_pin),
        .rx_read     (rx_read),
        .rx_word     (rx_word),
        .status      (status),
        .exp_push    (exp_push),
        .exp_word    (exp_word),
        .stat_req    (stat_req),
        .pin_chk     (pin_chk),
        .stat_exp    (stat_exp),
        .test_end    (test_end),
        .final_req   (final_req),
        .test_num    (test_num),
        .error_count (error_count)
    );

    task automatic fill_table();
        int r;
        int i;
        for (r = 0; r < NROWS; r++) begin
            row_bad_stop[r] = '0;
            for (i = 0; i < MAXB; i++) row_data[r][i] = '0;
        end
        row_kind[0] = K_RESET;    row_len[0] = 0;         row_exp[0] = 0;
        row_kind[1] = K_LOOP;     row_len[1] = 6;         row_exp[1] = 6;
        row_kind[2] = K_TXFULL;   row_len[2] = DEPTH + 2; row_exp[2] = DEPTH + 1;
        row_kind[3] = K_FRAME;    row_len[3] = 2;         row_exp[3] = 2;
        row_kind[4] = K_OVERFLOW; row_len[4] = DEPTH + 3; row_exp[4] = DEPTH;
        row_kind[5] = K_LOOP;     row_len[5] = 6;         row_exp[5] = 6;
        row_baud[0] = 8;
        row_baud[1] = 8;
        row_baud[2] = 200;
        row_baud[3] = 8;
        row_baud[4] = 8;
        row_baud[5] = 5;   // divisor change after running at 8
        row_data[3][0]  = 8'ha5;
        row_data[3][1]  = 8'h3c;
        row_bad_stop[3] = 'b01;   // first frame carries a low stop bit
        for (r = 0; r < NROWS; r++) begin
            if (row_kind[r] != K_RESET && row_kind[r] != K_FRAME) begin
                for (i = 0; i < row_len[r]; i++) row_data[r][i] = uart_byte_t'($urandom());
            end
        end
    endtask

    task automatic expect_word(input uart_byte_t d, input logic err);
        exp_word.data      = d;
        exp_word.frame_err = err;
        exp_push           = 1'b1;
        @(negedge clk);
        exp_push = 1'b0;
    endtask

    task automatic request_status_check(input uart_status_t exp, input logic pin);
        stat_exp = exp;
        pin_chk  = pin;
        stat_req = 1'b1;
        @(negedge clk);
        stat_req = 1'b0;
    endtask

    task automatic write_byte(input uart_byte_t d);
        tx_data  = d;
        tx_start = !tx_start;   // any change enqueues
        @(negedge clk);
    endtask

    task automatic send_frame(input uart_byte_t d, input logic stop, input int baud);
        int i;
        drv_pin = 1'b0;
        repeat (baud) @(negedge clk);
        for (i = 0; i < `UART_DATA_BITS; i++) begin
            drv_pin = d[i];   // lsb first
            repeat (baud) @(negedge clk);
        end
        drv_pin = stop;
        repeat (baud) @(negedge clk);
        drv_pin = 1'b1;
        repeat (baud) @(negedge clk);   // one idle bit between frames
    endtask

    task automatic pop_words(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            while (status.rx_ready !== 1'b1) @(negedge clk);
            rx_read = !rx_read;
            repeat (3) @(negedge clk);   // lets rx_ready catch up with the count
        end
    endtask

    task automatic run_row(input int r);
        int i;
        test_num = 8'(r);
        baud_div = `UART_DIV_BITS'(row_baud[r]);
        loopback = (row_kind[r] == K_LOOP) || (row_kind[r] == K_TXFULL);
        for (i = 0; i < row_exp[r]; i++) expect_word(row_data[r][i], row_bad_stop[r][i]);
        case (row_kind[r])
            K_RESET: request_status_check(3'b010, 1'b1);   // tx_full, tx_empty, rx_ready
            K_LOOP, K_TXFULL: begin
                for (i = 0; i < row_len[r]; i++) write_byte(row_data[r][i]);
                if (row_kind[r] == K_TXFULL) request_status_check(3'b100, 1'b0);
                pop_words(row_exp[r]);
            end
            default: begin
                for (i = 0; i < row_len[r]; i++) begin
                    send_frame(row_data[r][i], !row_bad_stop[r][i], row_baud[r]);
                end
                pop_words(row_exp[r]);
            end
        endcase
        if (row_kind[r] != K_RESET) request_status_check(3'b010, 1'b1);
        repeat (10 * row_baud[r]) @(negedge clk);   // a full frame time before baud changes
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles in test %0d", cycles, test_num);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int r;
        baud_div  = `UART_DIV_BITS'(8);
        tx_start  = 1'b0;
        tx_data   = '0;
        rx_read   = 1'b0;
        loopback  = 1'b1;
        drv_pin   = 1'b1;
        exp_push  = 1'b0;
        exp_word  = '0;
        stat_req  = 1'b0;
        pin_chk   = 1'b0;
        stat_exp  = '0;
        test_end  = 1'b0;
        final_req = 1'b0;
        test_num  = '0;
        rnd = $urandom(seed);
        fill_table();
        cycle_limit = MARGIN;
        for (r = 0; r < NROWS; r++) cycle_limit += row_len[r] * 10 * row_baud[r] * 2;
        wait (rst_n === 1'b1);
        @(negedge clk);
        for (r = 0; r < NROWS; r++) run_row(r);
        final_req = 1'b1;
        @(negedge clk);
        final_req = 1'b0;
        repeat (3) @(negedge clk);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart.sv
tests/uart_clock_gen.sv
tests/uart_checker.sv
tests/tb_uart.sv

// ==== Bender.yml ====
package:
  name: uart

sources:
  - include_dirs:
      - include
    files:
      - logic/uart_pkg.sv
      - logic/uart_fifo.sv
      - logic/uart_tx.sv
      - logic/uart_rx.sv
      - logic/uart.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/uart_clock_gen.sv
      - tests/uart_checker.sv
      - tests/tb_uart.sv
